/* test/fifo_cdc_stimulus.txt */
# cmd arg   W <packet hex> writes one packet   S <cycles> stalls the reader
# R gives random ready_in for the writes that follow
W 00000001
W deadbeef
W 12345678
W a5a5a5a5
W 5a5a5a5a
S 40
W 10000000
W 10000001
W 20000002
W 30000003
W 40000004
W 50000005
W 60000006
W 70000007
W 80000008
W 90000009
W a000000a
W b000000b
W c000000c
W d000000d
W e000000e
W f000000f
W 0badf00d
W cafe0011
S 6
W 11111111
W 22222222
W 33333333
W 44444444
R
W 0000ffff
W ffff0000
W 00ff00ff
W ff00ff00
W 0f0f0f0f
W f0f0f0f0
W 13579bdf
W 2468ace0

/* tb.f */
design/fifo_cdc_pkg.sv
design/reset_sync.sv
design/fifo_dual_port_ram.sv
design/fifo_write_ctrl.sv
design/fifo_read_ctrl.sv
design/fifo_async.sv
design/fifo_cdc.sv
test/tb_fifo_cdc.sv

/* Bender.yml */
package:
  name: fifo_cdc

sources:
  - design/fifo_cdc_pkg.sv
  - design/reset_sync.sv
  - design/fifo_dual_port_ram.sv
  - design/fifo_write_ctrl.sv
  - design/fifo_read_ctrl.sv
  - design/fifo_async.sv
  - design/fifo_cdc.sv
  - target: test
    files:
      - test/tb_fifo_cdc.sv

/* test/tb_fifo_cdc.sv */
module tb_fifo_cdc;
   timeunit 1ns;
   timeprecision 1ps;

   logic                  clk_in;
   logic                  clk_out;
   logic                  nreset_out;
   logic                  valid_in;
   fifo_cdc_pkg::packet_t packet_in;
   logic                  ready_out;
   logic                  valid_out;
   fifo_cdc_pkg::packet_t packet_out;
   logic                  ready_in;
   logic                  prog_full;
   logic                  full;
   logic                  empty;

   byte                   cmd_kind [$];   // W, S or R per stimulus line
   logic [31:0]           cmd_arg [$];
   fifo_cdc_pkg::packet_t expected_q [$]; // scoreboard in write order
   fifo_cdc_pkg::packet_t last_packet;
   logic                  last_valid;
   logic                  random_mode;
   logic                  reset_done;
   logic                  saw_prog_full;
   logic [31:0]           lcg_state;
   int                    written_count;
   int                    delivered_count;
   int                    error_count;
   int                    cycle_count;
   int                    timeout_limit;
   int                    stall_left;     // reader stall cycles still to go

   always #7 clk_in = ~clk_in;   // 14 ns
   always #10 clk_out = ~clk_out; // 20 ns

   fifo_cdc DUT (
      .nreset_out (nreset_out),
      .clk_in     (clk_in),
      .valid_in   (valid_in),
      .packet_in  (packet_in),
      .ready_out  (ready_out),
      .clk_out    (clk_out),
      .valid_out  (valid_out),
      .packet_out (packet_out),
      .ready_in   (ready_in),
      .prog_full  (prog_full),
      .full       (full),
      .empty      (empty)
   );

   // ####################
   // checking helpers
   // ####################

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic halt_with_failure();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic report_problem(input string text);
      error_count++;
      $display("%s", text);
      halt_with_failure();
   endtask

   task automatic check_packet(input string name, input fifo_cdc_pkg::packet_t expected,
                               input fifo_cdc_pkg::packet_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL %s expected %h got %h", name, expected, actual);
         halt_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL %s expected %h got %h", name, expected, actual);
         halt_with_failure();
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         error_count++;
         $display("FAIL %s expected %h got %h", name, expected, actual);
         halt_with_failure();
      end
   endtask

   // ####################
   // stimulus
   // ####################

   task automatic load_stimulus();
      int               fd;
      int               code;
      logic [63:0]      token;
      logic [31:0]      value;
      logic [8*128-1:0] rest;
      fd = $fopen("test/fifo_cdc_stimulus.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open the stimulus file");
      end
      code = $fscanf(fd, "%s", token);
      while (code == 1) begin
         if (token == "#") begin
            code = $fgets(rest, fd); // rest of a comment line
         end else if (token == "W") begin
            code = $fscanf(fd, "%h", value);
            cmd_kind.push_back("W");
            cmd_arg.push_back(value);
         end else if (token == "S") begin
            code = $fscanf(fd, "%d", value); // stall length in clk_out cycles
            cmd_kind.push_back("S");
            cmd_arg.push_back(value);
         end else if (token == "R") begin
            cmd_kind.push_back("R");
            cmd_arg.push_back('0);
         end else begin
            report_problem("unknown command in the stimulus file");
         end
         code = $fscanf(fd, "%s", token);
      end
      $fclose(fd);
   endtask

   // one write held back while ready_out is low
   task automatic write_packet(input fifo_cdc_pkg::packet_t value);
      @(negedge clk_in);
      while (!ready_out) begin
         valid_in = 1'b0;
         @(negedge clk_in);
      end
      valid_in  = 1'b1;
      packet_in = value;
      expected_q.push_back(value);
      written_count++;
   endtask

   // new packet on the output against the queue head
   task automatic take_packet();
      if (expected_q.size() == 0) begin
         report_problem("packet_out delivered with no packet outstanding");
      end else begin
         check_packet("packet_out", expected_q.pop_front(), packet_out);
         delivered_count++;
      end
   endtask

   // ####################
   // main sequence
   // ####################

   initial begin
      clk_in          = 1'b0;
      clk_out         = 1'b0;
      nreset_out      = 1'b0;
      valid_in        = 1'b0;
      packet_in       = '0;
      ready_in        = 1'b0;
      last_valid      = 1'b0;
      last_packet     = '0;
      random_mode     = 1'b0;
      reset_done      = 1'b0;
      saw_prog_full   = 1'b0;
      lcg_state       = 32'h275e;
      written_count   = 0;
      delivered_count = 0;
      error_count     = 0;
      cycle_count     = 0;
      stall_left      = 0;
      load_stimulus();
      timeout_limit = cmd_kind.size() * 40 + 4 * fifo_cdc_pkg::DEPTH;

      repeat (4) @(negedge clk_out); // 4 cycles in reset
      nreset_out = 1'b1;
      repeat (3) @(negedge clk_out); // both sync chains released
      check_bit("valid_out", 1'b0, valid_out);
      check_bit("full", 1'b0, full);
      check_bit("prog_full", 1'b0, prog_full);
      check_bit("empty", 1'b1, empty);
      check_bit("ready_out", 1'b1, ready_out);
      reset_done = 1'b1;

      foreach (cmd_kind[i]) begin
         case (cmd_kind[i])
            "W": write_packet(cmd_arg[i]);
            "S": begin
               random_mode = 1'b0;
               stall_left  = cmd_arg[i];
            end
            default: random_mode = 1'b1;
         endcase
      end
      @(negedge clk_in);
      valid_in    = 1'b0;
      random_mode = 1'b0; // reader drains at full rate

      // last write reaches the read side within SYNC_STAGES+1 cycles
      repeat (fifo_cdc_pkg::SYNC_STAGES + 2) @(negedge clk_out);
      while (!empty || valid_out) begin
         @(negedge clk_out); // drain until the output side goes idle
      end
      repeat (4) @(negedge clk_out); // nothing extra may show up
      check_bit("empty", 1'b1, empty);
      check_bit("valid_out", 1'b0, valid_out);
      check_count("delivered_count", written_count, delivered_count);
      if (!saw_prog_full) begin
         report_problem("prog_full never rose during the long stall");
      end
      if (error_count == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         halt_with_failure();
      end
   end

   // reader and scoreboard with ready_in driven on falling clk_out
   initial begin
      wait (reset_done);
      forever begin
         @(negedge clk_out);
         if (ready_in) begin
            if (valid_out) begin
               take_packet(); // loaded at the last edge
            end
         end else begin
            check_bit("valid_out", last_valid, valid_out); // stalled so it must hold
            if (last_valid) begin
               check_packet("packet_out", last_packet, packet_out);
            end
         end
         last_valid  = valid_out;
         last_packet = packet_out;
         if (stall_left > 0) begin
            ready_in = 1'b0;
            stall_left--;
         end else if (random_mode) begin
            lcg_state = lcg_next(lcg_state);
            ready_in  = lcg_state[16];
         end else begin
            ready_in = 1'b1;
         end
      end
   end

   // write side flags
   initial begin
      wait (reset_done);
      forever begin
         @(negedge clk_in);
         check_bit("full", 1'b0, full); // never that many outstanding
         if (prog_full) begin
            saw_prog_full = 1'b1;
            check_bit("ready_out", 1'b0, ready_out);
         end
      end
   end

   // watchdog
   always @(posedge clk_out) begin
      cycle_count++;
      if (cycle_count > timeout_limit) begin
         report_problem("run exceeded the clk_out cycle limit without finishing");
      end
   end

endmodule

/* design/fifo_cdc.sv */
module fifo_cdc (
   input  logic                  nreset_out, // async and active low
   // write side
   input  logic                  clk_in,
   input  logic                  valid_in,
   input  fifo_cdc_pkg::packet_t packet_in,
   output logic                  ready_out,  // writer may only push when high
   // read side
   input  logic                  clk_out,
   output logic                  valid_out,
   output fifo_cdc_pkg::packet_t packet_out,
   input  logic                  ready_in,   // low stalls the output
   // status
   output logic                  prog_full,
   output logic                  full,
   output logic                  empty
);

   logic wr_nreset;   // clk_in domain reset
   logic rd_nreset;   // clk_out domain reset
   logic almost_full;
   logic rd_en;

   // ####################
   // resets
   // ####################

   reset_sync u_wr_rst (
      .clk_out     (clk_in), // write domain clock
      .nreset_out  (nreset_out),
      .sync_nreset (wr_nreset)
   );

   reset_sync u_rd_rst (
      .clk_out     (clk_out),
      .nreset_out  (nreset_out),
      .sync_nreset (rd_nreset)
   );

   // ####################
   // handshake
   // ####################

   assign rd_en     = ~empty & ready_in;
   assign ready_out = ~(almost_full | full | prog_full); // prog_full trips first

   // valid follows the registered read data and freezes while stalled
   always_ff @(posedge clk_out or negedge rd_nreset) begin
      if (!rd_nreset) begin
         valid_out <= 1'b0;
      end else if (ready_in) begin
         valid_out <= rd_en;
      end
   end

   fifo_async u_fifo (
      .clk_in      (clk_in),
      .wr_nreset   (wr_nreset),
      .wr_en       (valid_in),
      .wr_data     (packet_in),
      .clk_out     (clk_out),
      .rd_nreset   (rd_nreset),
      .rd_en       (rd_en),
      .rd_data     (packet_out),
      .full        (full),
      .almost_full (almost_full),
      .prog_full   (prog_full),
      .empty       (empty)
   );

   // writer obeys ready_out
   a_valid_needs_ready : assert property (
      @(posedge clk_in) disable iff (!wr_nreset) valid_in |-> ready_out
   );

endmodule

/* design/fifo_async.sv */
module fifo_async (
   // write domain
   input  logic                  clk_in,
   input  logic                  wr_nreset,
   input  logic                  wr_en,
   input  fifo_cdc_pkg::packet_t wr_data,
   // read domain
   input  logic                  clk_out,
   input  logic                  rd_nreset,
   input  logic                  rd_en,
   output fifo_cdc_pkg::packet_t rd_data,
   // status
   output logic                  full,
   output logic                  almost_full,
   output logic                  prog_full,
   output logic                  empty
);

   fifo_cdc_pkg::ptr_t  wr_ptr_gray; // clk_in -> clk_out
   fifo_cdc_pkg::ptr_t  rd_ptr_gray; // clk_out -> clk_in
   fifo_cdc_pkg::addr_t wr_addr;
   fifo_cdc_pkg::addr_t rd_addr;
   logic                mem_wr_en;

   // same gating as the write pointer uses
   assign mem_wr_en = wr_en & ~full;

   fifo_write_ctrl u_wr_ctrl (
      .clk_in      (clk_in),
      .wr_nreset   (wr_nreset),
      .wr_en       (wr_en),
      .rd_ptr_gray (rd_ptr_gray),
      .wr_ptr_gray (wr_ptr_gray),
      .wr_addr     (wr_addr),
      .full        (full),
      .almost_full (almost_full),
      .prog_full   (prog_full)
   );

   fifo_read_ctrl u_rd_ctrl (
      .clk_out     (clk_out),
      .rd_nreset   (rd_nreset),
      .rd_en       (rd_en),
      .wr_ptr_gray (wr_ptr_gray),
      .rd_ptr_gray (rd_ptr_gray),
      .rd_addr     (rd_addr),
      .empty       (empty)
   );

   fifo_dual_port_ram #(.payload_t(fifo_cdc_pkg::packet_t)) u_ram (
      .clk_in  (clk_in),
      .wr_en   (mem_wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .clk_out (clk_out),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* design/fifo_read_ctrl.sv */
module fifo_read_ctrl (
   input  logic                clk_out,
   input  logic                rd_nreset,
   input  logic                rd_en,        // pop request
   input  fifo_cdc_pkg::ptr_t  wr_ptr_gray,  // from clk_in domain
   output fifo_cdc_pkg::ptr_t  rd_ptr_gray,  // back to clk_in domain
   output fifo_cdc_pkg::addr_t rd_addr,
   output logic                empty
);

   fifo_cdc_pkg::ptr_t rd_ptr_bin;
   fifo_cdc_pkg::ptr_t rd_ptr_bin_next;
   fifo_cdc_pkg::ptr_t rd_ptr_gray_next;
   fifo_cdc_pkg::ptr_t wr_sync [fifo_cdc_pkg::SYNC_STAGES]; // 2ff chain
   logic               pop;

   // ####################
   // local pointer
   // ####################

   assign pop              = rd_en & ~empty; // never read past the writer
   assign rd_ptr_bin_next  = rd_ptr_bin + fifo_cdc_pkg::ptr_t'(pop);
   assign rd_ptr_gray_next = rd_ptr_bin_next ^ (rd_ptr_bin_next >> 1);
   assign rd_addr          = rd_ptr_bin[fifo_cdc_pkg::ADDR_W-1:0];

   always_ff @(posedge clk_out or negedge rd_nreset) begin
      if (!rd_nreset) begin
         rd_ptr_bin  <= '0;
         rd_ptr_gray <= '0;
      end else begin
         rd_ptr_bin  <= rd_ptr_bin_next;
         rd_ptr_gray <= rd_ptr_gray_next; // published to write side
      end
   end

   // write pointer into clk_out
   always_ff @(posedge clk_out or negedge rd_nreset) begin
      if (!rd_nreset) begin
         wr_sync <= '{default: '0};
      end else begin
         wr_sync[0] <= wr_ptr_gray;
         for (int i = 1; i < fifo_cdc_pkg::SYNC_STAGES; i++) begin
            wr_sync[i] <= wr_sync[i-1];
         end
      end
   end

   // equal gray pointers incl wrap bit mean empty
   always_ff @(posedge clk_out or negedge rd_nreset) begin
      if (!rd_nreset) begin
         empty <= 1'b1;
      end else begin
         empty <= (rd_ptr_gray_next == wr_sync[fifo_cdc_pkg::SYNC_STAGES-1]);
      end
   end

   // reader side must check empty first
   a_no_read_empty : assert property (
      @(posedge clk_out) disable iff (!rd_nreset) rd_en |-> !empty
   );

endmodule

/* design/fifo_write_ctrl.sv */
module fifo_write_ctrl (
   input  logic                clk_in,
   input  logic                wr_nreset,
   input  logic                wr_en,        // write request from the writer
   input  fifo_cdc_pkg::ptr_t  rd_ptr_gray,  // from clk_out domain
   output fifo_cdc_pkg::ptr_t  wr_ptr_gray,  // to clk_out domain
   output fifo_cdc_pkg::addr_t wr_addr,
   output logic                full,
   output logic                almost_full,
   output logic                prog_full
);

   fifo_cdc_pkg::ptr_t wr_ptr_bin;
   fifo_cdc_pkg::ptr_t wr_ptr_bin_next;
   fifo_cdc_pkg::ptr_t rd_sync [fifo_cdc_pkg::SYNC_STAGES]; // 2ff chain
   fifo_cdc_pkg::ptr_t rd_ptr_bin;      // synced read pointer in binary
   fifo_cdc_pkg::ptr_t level_next;      // occupancy after this edge
   logic               push;

   // ####################
   // local pointer
   // ####################

   assign push            = wr_en & ~full; // drop writes into a full fifo
   assign wr_ptr_bin_next = wr_ptr_bin + fifo_cdc_pkg::ptr_t'(push);
   assign wr_addr         = wr_ptr_bin[fifo_cdc_pkg::ADDR_W-1:0]; // strip wrap bit

   always_ff @(posedge clk_in or negedge wr_nreset) begin
      if (!wr_nreset) begin
         wr_ptr_bin  <= '0;
         wr_ptr_gray <= '0;
      end else begin
         wr_ptr_bin  <= wr_ptr_bin_next;
         wr_ptr_gray <= wr_ptr_bin_next ^ (wr_ptr_bin_next >> 1); // bin to gray
      end
   end

   // ####################
   // remote pointer
   // ####################

   always_ff @(posedge clk_in or negedge wr_nreset) begin
      if (!wr_nreset) begin
         rd_sync <= '{default: '0};
      end else begin
         rd_sync[0] <= rd_ptr_gray; // first flop may go metastable
         for (int i = 1; i < fifo_cdc_pkg::SYNC_STAGES; i++) begin
            rd_sync[i] <= rd_sync[i-1];
         end
      end
   end

   // gray to binary from the msb down
   always_comb begin
      rd_ptr_bin[fifo_cdc_pkg::PTR_W-1] =
         rd_sync[fifo_cdc_pkg::SYNC_STAGES-1][fifo_cdc_pkg::PTR_W-1];
      for (int i = fifo_cdc_pkg::PTR_W-2; i >= 0; i--) begin
         rd_ptr_bin[i] = rd_ptr_bin[i+1] ^ rd_sync[fifo_cdc_pkg::SYNC_STAGES-1][i];
      end
   end

   // modulo difference where the wrap bit makes DEPTH representable
   assign level_next = wr_ptr_bin_next - rd_ptr_bin;

   // flags from next state so they move with the pointer
   always_ff @(posedge clk_in or negedge wr_nreset) begin
      if (!wr_nreset) begin
         full        <= 1'b0;
         almost_full <= 1'b0;
         prog_full   <= 1'b0;
      end else begin
         full        <= (level_next == fifo_cdc_pkg::DEPTH);
         almost_full <= (level_next >= fifo_cdc_pkg::ALMOST_FULL_LEVEL);
         prog_full   <= (level_next >= fifo_cdc_pkg::PROG_FULL_LEVEL);
      end
   end

   // writer must respect the flags
   a_no_write_full : assert property (
      @(posedge clk_in) disable iff (!wr_nreset) wr_en |-> !full
   );

endmodule

/* design/fifo_dual_port_ram.sv */
module fifo_dual_port_ram #(
   parameter type payload_t = fifo_cdc_pkg::packet_t
) (
   // write port
   input  logic                clk_in,
   input  logic                wr_en,
   input  fifo_cdc_pkg::addr_t wr_addr,
   input  payload_t            wr_data,
   // read port
   input  logic                clk_out,
   input  logic                rd_en,
   input  fifo_cdc_pkg::addr_t rd_addr,
   output payload_t            rd_data
);

   payload_t mem [fifo_cdc_pkg::DEPTH]; // storage

   // write in the clk_in domain
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read that holds while rd_en is low
   always_ff @(posedge clk_out) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr]; // one cycle latency
      end
   end

endmodule

/* design/reset_sync.sv */
module reset_sync (
   input  logic clk_out,     // clock of the domain being reset
   input  logic nreset_out,  // raw async reset, active low
   output logic sync_nreset  // reset for this domain
);

   logic [1:0] sync_ff; // shift chain that a one walks into after release

   // clear at once and release after two edges
   always_ff @(posedge clk_out or negedge nreset_out) begin
      if (!nreset_out) begin
         sync_ff <= 2'b00;
      end else begin
         sync_ff <= {sync_ff[0], 1'b1};
      end
   end

   assign sync_nreset = sync_ff[1];

endmodule

/* design/fifo_cdc_pkg.sv */
package fifo_cdc_pkg;

   // ####################
   // fifo geometry
   // ####################

   localparam int PACKET_W = 32;            // payload bits per entry
   localparam int DEPTH    = 32;            // power of two entries
   localparam int ADDR_W   = $clog2(DEPTH); // memory address bits
   localparam int PTR_W    = ADDR_W + 1;    // extra msb tells wrap from empty

   // ####################
   // flag thresholds
   // ####################

   // write side occupancy levels compared with >=
   localparam int PROG_FULL_LEVEL   = DEPTH / 2; // half full throttles the writer
   localparam int ALMOST_FULL_LEVEL = DEPTH - 1; // one slot left

   // flops per synchronizer chain
   localparam int SYNC_STAGES = 2;

   // ####################
   // types
   // ####################

   // one packet as stored in the memory
   typedef logic [PACKET_W-1:0] packet_t;

   // binary or gray pointer with wrap bit
   typedef logic [PTR_W-1:0] ptr_t;

   // memory index without the wrap bit
   typedef logic [ADDR_W-1:0] addr_t;

   // the gray pointer scheme only holds
   // when DEPTH is a power of two so the msb
   // of a pointer flips exactly on wrap

endpackage
